//--- logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [2:0]      funct3_t;
    typedef logic [3:0]      mem_mask_t;

    // ********************
    // major opcodes
    // ********************
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_SYSTEM = 7'b1110011;

    typedef enum logic [2:0] {R, I, S, B, U, J, NONE} inst_type_e;

    // low eight codes line up with {funct7[5], funct3}
    typedef enum logic [4:0] {
        ADD      = 5'd0,
        SLL      = 5'd1,
        SLT      = 5'd2,
        SLTU     = 5'd3,
        XOR      = 5'd4,
        SRL      = 5'd5,
        OR       = 5'd6,
        AND      = 5'd7,
        SUB      = 5'd8,
        SRA      = 5'd13,
        EQ       = 5'd16,
        NE       = 5'd17,
        LT       = 5'd18,
        GE       = 5'd19,
        LTU      = 5'd20,
        GEU      = 5'd21,
        NO_FUNCT = 5'd31
    } alu_funct_e;

    typedef struct packed {
        logic       pc_en;
        logic       is_branch;
        logic       is_jal;
        logic       is_jalr;
        logic       gpr_w_en;
        logic       alu_b_is_imm;
        alu_funct_e alu_funct;
        logic       mem_r_en;
        logic       mem_w_en;
        mem_mask_t  mem_size;      // unshifted byte mask
        logic       load_unsigned;
        logic       rd_is_mem;
        logic       is_lui;
        logic       is_auipc;
    } ctrl_t;

    typedef struct packed {
        opcode_t    opcode;
        funct3_t    funct3;
        logic       funct7_5;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        inst_type_e inst_type;
    } fields_t;

endpackage

`default_nettype wire

//--- logic/rv_ctrl.sv
`default_nettype none

module rv_ctrl (
    input  wire rv_pkg::fields_t fields,
    input  wire                  halted,
    output rv_pkg::ctrl_t        ctrl
);

    import rv_pkg::*;

    alu_funct_e branch_funct;
    alu_funct_e op_funct;
    logic       pc_en;

    // branch compare select
    always_comb begin
        case (fields.funct3)
            3'b000:  branch_funct = EQ;
            3'b001:  branch_funct = NE;
            3'b100:  branch_funct = LT;
            3'b101:  branch_funct = GE;
            3'b110:  branch_funct = LTU;
            3'b111:  branch_funct = GEU;
            default: branch_funct = NO_FUNCT;
        endcase
    end

    assign op_funct = alu_funct_e'({1'b0, fields.funct7_5, fields.funct3});

    // ecall stops the core here
    assign pc_en = !halted && (fields.opcode != OP_SYSTEM);

    always_comb begin
        ctrl = '0;
        ctrl.pc_en        = pc_en;
        ctrl.is_branch    = fields.opcode == OP_BRANCH;
        ctrl.is_jal       = fields.opcode == OP_JAL;
        ctrl.is_jalr      = fields.opcode == OP_JALR;
        ctrl.gpr_w_en     = pc_en && (fields.inst_type inside {R, I, U, J});
        ctrl.alu_b_is_imm = fields.inst_type inside {I, S};
        ctrl.mem_r_en     = pc_en && (fields.opcode == OP_LOAD);
        ctrl.mem_w_en     = pc_en && (fields.opcode == OP_STORE);
        ctrl.rd_is_mem    = fields.opcode == OP_LOAD;
        ctrl.is_lui       = fields.opcode == OP_LUI;
        ctrl.is_auipc     = fields.opcode == OP_AUIPC;

        case (fields.funct3[1:0])
            2'b00:   ctrl.mem_size = 4'b0001;
            2'b01:   ctrl.mem_size = 4'b0011;
            default: ctrl.mem_size = 4'b1111;
        endcase
        ctrl.load_unsigned = fields.funct3[2];

        case (fields.opcode)
            OP_AUIPC, OP_JALR, OP_LOAD, OP_STORE: begin
                ctrl.alu_funct = ADD;
            end
            OP_BRANCH: ctrl.alu_funct = branch_funct;
            OP_IMM: begin
                // only the right shifts look at funct7
                ctrl.alu_funct = (fields.funct3 == 3'b101) ? op_funct
                               : alu_funct_e'({2'b00, fields.funct3});
            end
            OP_REG:  ctrl.alu_funct = op_funct;
            default: ctrl.alu_funct = NO_FUNCT;
        endcase
    end

    // opcode decode here and the format from rv_decode must agree
    always_comb begin
        assert (!ctrl.mem_r_en || (fields.inst_type == I))
            else $error("rv_ctrl: load not decoded as I format");
        assert (!ctrl.mem_w_en || (fields.inst_type == S))
            else $error("rv_ctrl: store not decoded as S format");
    end

endmodule

`default_nettype wire

//--- logic/rv_decode.sv
`default_nettype none

module rv_decode (
    input  wire rv_pkg::word_t inst,
    output rv_pkg::fields_t    fields,
    output rv_pkg::word_t      imm
);

    import rv_pkg::*;

    opcode_t opcode;

    assign opcode = inst[6:0];

    always_comb begin
        fields.opcode   = opcode;
        fields.funct3   = inst[14:12];
        fields.funct7_5 = inst[30];
        fields.rs1      = inst[19:15];
        fields.rs2      = inst[24:20];
        fields.rd       = inst[11:7];

        case (opcode)
            OP_REG:                   fields.inst_type = R;
            OP_IMM, OP_LOAD, OP_JALR: fields.inst_type = I;
            OP_STORE:                 fields.inst_type = S;
            OP_BRANCH:                fields.inst_type = B;
            OP_LUI, OP_AUIPC:         fields.inst_type = U;
            OP_JAL:                   fields.inst_type = J;
            default:                  fields.inst_type = NONE;
        endcase
    end

    // ********************
    // immediate assembly
    // ********************
    always_comb begin
        case (fields.inst_type)
            I: imm = {{20{inst[31]}}, inst[31:20]};
            S: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            B: begin
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                       inst[11:8], 1'b0};
            end
            U: imm = {inst[31:12], 12'b0};
            J: begin
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                       inst[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/rv_regfile.sv
`default_nettype none

module rv_regfile (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire rv_pkg::reg_idx_t rs1,
    input  wire rv_pkg::reg_idx_t rs2,
    input  wire rv_pkg::reg_idx_t rd,
    input  wire                   w_en,
    input  wire rv_pkg::word_t    w_data,
    output rv_pkg::word_t         rs1_data,
    output rv_pkg::word_t         rs2_data
);

    import rv_pkg::*;

    word_t regs [32];

    // x0 is cleared at reset and never written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (w_en && (rd != '0)) begin
            regs[rd] <= w_data;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

`default_nettype wire

//--- logic/rv_alu.sv
`default_nettype none

module rv_alu (
    input  wire rv_pkg::alu_funct_e funct,
    input  wire rv_pkg::word_t      a,
    input  wire rv_pkg::word_t      b,
    output rv_pkg::word_t           result
);

    import rv_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;
    logic       eq;

    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;
    assign eq    = a == b;

    always_comb begin
        case (funct)
            ADD:      result = a + b;
            SUB:      result = a - b;
            SLL:      result = a << shamt;
            SRL:      result = a >> shamt;
            SRA:      result = word_t'($signed(a) >>> shamt);
            SLT:      result = word_t'(lt_s);
            SLTU:     result = word_t'(lt_u);
            XOR:      result = a ^ b;
            OR:       result = a | b;
            AND:      result = a & b;

            // ********************
            // branch compares, flag in bit 0
            // ********************
            EQ:       result = word_t'(eq);
            NE:       result = word_t'(!eq);
            LT:       result = word_t'(lt_s);
            GE:       result = word_t'(!lt_s);
            LTU:      result = word_t'(lt_u);
            GEU:      result = word_t'(!lt_u);

            NO_FUNCT: result = b;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/rv_lsu.sv
`default_nettype none

module rv_lsu (
    input  wire                rst_n,
    input  wire rv_pkg::ctrl_t ctrl,
    input  wire rv_pkg::word_t addr,
    input  wire rv_pkg::word_t store_data,
    output rv_pkg::word_t      dmem_addr,
    output rv_pkg::word_t      dmem_wdata,
    output rv_pkg::mem_mask_t  dmem_mask,
    output logic               dmem_w_en,
    output logic               dmem_r_en,
    input  wire rv_pkg::word_t dmem_rdata,
    output rv_pkg::word_t      load_data
);

    import rv_pkg::*;

    logic [1:0] offset;
    word_t      lane;

    assign offset    = addr[1:0];
    assign dmem_addr = {addr[XLEN-1:2], 2'b00};

    // byte lanes follow the low address bits
    assign dmem_mask  = ctrl.mem_size << offset;
    assign dmem_wdata = store_data << {offset, 3'b000};

    assign dmem_w_en = rst_n && ctrl.mem_w_en;
    assign dmem_r_en = rst_n && ctrl.mem_r_en;

    // addressed byte down to bit 0
    assign lane = dmem_rdata >> {offset, 3'b000};

    always_comb begin
        case (ctrl.mem_size)
            4'b0001: begin
                load_data = ctrl.load_unsigned ? word_t'(lane[7:0])
                          : {{24{lane[7]}}, lane[7:0]};
            end
            4'b0011: begin
                load_data = ctrl.load_unsigned ? word_t'(lane[15:0])
                          : {{16{lane[15]}}, lane[15:0]};
            end
            default: load_data = lane;
        endcase
    end

    always_comb begin
        if (rst_n && (ctrl.mem_r_en || ctrl.mem_w_en) && (ctrl.mem_size == 4'b0011)) begin
            assert (!addr[0])
                else $error("rv_lsu: misaligned half access at %h", addr);
        end
    end

endmodule

`default_nettype wire

//--- logic/rv_fetch.sv
`default_nettype none

module rv_fetch #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  wire                clk,
    input  wire                rst_n,
    input  wire rv_pkg::ctrl_t ctrl,
    input  wire rv_pkg::word_t imm,
    input  wire rv_pkg::word_t rs1_data,
    input  wire                take_branch,
    output rv_pkg::word_t      pc,
    output logic               halted
);

    import rv_pkg::*;

    word_t jalr_target;
    word_t next_pc;

    assign jalr_target = rs1_data + imm;

    always_comb begin
        if (ctrl.is_jalr) begin
            next_pc = {jalr_target[XLEN-1:1], 1'b0};
        end else if (take_branch || ctrl.is_jal) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc + word_t'(4);
        end
    end

    // pc_en drops only for ecall or an already halted core
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc     <= RESET_PC;
            halted <= 1'b0;
        end else if (ctrl.pc_en) begin
            pc <= next_pc;
        end else begin
            halted <= 1'b1;
        end
    end

    // parked for good once halted
    assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted && $stable(pc));

endmodule

`default_nettype wire

//--- logic/rv_core.sv
`default_nettype none

module rv_core #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  wire                clk,
    input  wire                rst_n,
    output rv_pkg::word_t      imem_addr,
    input  wire rv_pkg::word_t imem_data,
    output rv_pkg::word_t      dmem_addr,
    output rv_pkg::word_t      dmem_wdata,
    output rv_pkg::mem_mask_t  dmem_mask,
    output logic               dmem_w_en,
    output logic               dmem_r_en,
    input  wire rv_pkg::word_t dmem_rdata,
    output logic               halted
);

    import rv_pkg::*;

    fields_t fields;
    ctrl_t   ctrl;
    word_t   pc;
    word_t   pc_plus4;
    word_t   imm;
    word_t   rs1_data;
    word_t   rs2_data;
    word_t   alu_a;
    word_t   alu_b;
    word_t   alu_result;
    word_t   load_data;
    word_t   wb_data;
    logic    take_branch;

    assign imem_addr   = pc;
    assign pc_plus4    = pc + word_t'(4);
    assign take_branch = ctrl.is_branch && alu_result[0];

    // ********************
    // operand and write-back select
    // ********************
    assign alu_a = ctrl.is_auipc ? pc : rs1_data;
    assign alu_b = (ctrl.alu_b_is_imm || ctrl.is_auipc) ? imm : rs2_data;

    always_comb begin
        if (ctrl.rd_is_mem) begin
            wb_data = load_data;
        end else if (ctrl.is_jal || ctrl.is_jalr) begin
            wb_data = pc_plus4;
        end else if (ctrl.is_lui) begin
            wb_data = imm;
        end else begin
            wb_data = alu_result;
        end
    end

    rv_decode decode0 (.inst(imem_data), .fields(fields), .imm(imm));

    rv_ctrl ctrl0 (.fields(fields), .halted(halted), .ctrl(ctrl));

    rv_regfile regfile0 (
        .clk(clk), .rst_n(rst_n), .rs1(fields.rs1), .rs2(fields.rs2), .rd(fields.rd),
        .w_en(ctrl.gpr_w_en), .w_data(wb_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    rv_alu alu0 (.funct(ctrl.alu_funct), .a(alu_a), .b(alu_b), .result(alu_result));

    rv_lsu lsu0 (
        .rst_n(rst_n), .ctrl(ctrl), .addr(alu_result), .store_data(rs2_data),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_mask(dmem_mask),
        .dmem_w_en(dmem_w_en), .dmem_r_en(dmem_r_en), .dmem_rdata(dmem_rdata),
        .load_data(load_data)
    );

    rv_fetch #(.RESET_PC(RESET_PC)) fetch0 (
        .clk(clk), .rst_n(rst_n), .ctrl(ctrl), .imm(imm), .rs1_data(rs1_data),
        .take_branch(take_branch), .pc(pc), .halted(halted)
    );

endmodule

`default_nettype wire

//--- bench/core_checker.sv
`default_nettype none

module core_checker #(
    parameter int MAX_STORES = 64
) (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         dmem_w_en,
    input  wire         dmem_r_en,
    input  wire  [31:0] dmem_addr,
    input  wire  [31:0] dmem_wdata,
    input  wire  [3:0]  dmem_mask,
    input  wire         halted,
    input  logic [31:0] exp_addr [MAX_STORES],
    input  logic [31:0] exp_data [MAX_STORES],
    input  logic [3:0]  exp_mask [MAX_STORES],
    input  int          n_exp,
    input  int          n_loads,
    output int          error_count,
    output int          store_count,
    output int          load_count
);

    // bytes outside the mask are don't care
    function automatic logic [31:0] lanes(input logic [3:0] mask);
        logic [31:0] m;
        for (int i = 0; i < 4; i++) begin
            m[8*i +: 8] = {8{mask[i]}};
        end
        return m;
    endfunction

    initial begin
        error_count = 0;
        store_count = 0;
        load_count = 0;
    end

    always @(posedge clk) begin
        if (rst_n && dmem_r_en) begin
            if (load_count >= n_loads) begin
                $display("load from %h that the program should never make", dmem_addr);
                error_count = error_count + 1;
            end
            load_count = load_count + 1;
        end
        if (rst_n && dmem_w_en) begin
            if (halted) begin
                $display("store to %h after the core halted", dmem_addr);
                error_count = error_count + 1;
            end else if (store_count >= n_exp) begin
                $display("store to %h that the program should never make", dmem_addr);
                error_count = error_count + 1;
            end else begin
                if (dmem_addr !== exp_addr[store_count]) begin
                    $display("error dmem_addr: expected %h, got %h",
                             exp_addr[store_count], dmem_addr);
                    error_count = error_count + 1;
                end
                if (dmem_mask !== exp_mask[store_count]) begin
                    $display("error dmem_mask: expected %h, got %h",
                             exp_mask[store_count], dmem_mask);
                    error_count = error_count + 1;
                end
                if ((dmem_wdata & lanes(exp_mask[store_count])) !==
                    (exp_data[store_count] & lanes(exp_mask[store_count]))) begin
                    $display("error dmem_wdata: expected %h, got %h (store %0d)",
                             exp_data[store_count], dmem_wdata, store_count);
                    error_count = error_count + 1;
                end
                store_count = store_count + 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_core.sv
`default_nettype none

module tb_core;

    localparam int PERIOD = 40;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic [3:0]  dmem_mask;
    logic        dmem_w_en;
    logic        dmem_r_en;
    logic [31:0] dmem_rdata;
    logic        halted;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] prog [256];
    logic [31:0] exp_addr [64];
    logic [31:0] exp_data [64];
    logic [3:0]  exp_mask [64];
    int          n_rows;
    int          n_exp;
    int          n_loads;
    int          seed;
    logic [31:0] st_addr;
    int          error_count;
    int          store_count;
    int          load_count;

    // ********************
    // instruction encoders
    // ********************
    function automatic logic [31:0] enc_r(input logic [31:0] f7, rs2, rs1, f3, rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [31:0] imm, rs1, f3, rd, op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] enc_s(input logic [31:0] imm, rs2, rs1, f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input logic [31:0] imm, rs2, rs1, f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_u(input logic [31:0] imm, rd, op);
        return {imm[19:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] enc_j(input logic [31:0] imm, rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    // ********************
    // table building
    // ********************
    task automatic put(input logic [31:0] inst);
        prog[n_rows] = inst;
        n_rows = n_rows + 1;
    endtask

    task automatic put_store(input logic [31:0] inst, addr, data, input logic [3:0] mask);
        put(inst);
        exp_addr[n_exp] = addr;
        exp_data[n_exp] = data;
        exp_mask[n_exp] = mask;
        n_exp = n_exp + 1;
    endtask

    // sw of one register to the next free result word
    task automatic store_word(input logic [31:0] rs, data);
        put_store(enc_s(st_addr, rs, 0, 2), st_addr, data, 4'hf);
        st_addr = st_addr + 4;
    endtask

    // one instruction, then sw of its result register
    task automatic run_and_store(input logic [31:0] inst, rs, data);
        put(inst);
        store_word(rs, data);
    endtask

    // load into a register, then sw of that register
    task automatic load_and_store(input logic [31:0] inst, rs, data);
        put(inst);
        n_loads = n_loads + 1;
        store_word(rs, data);
    endtask

    task automatic branch_case(input logic [31:0] f3, rs1, rs2, input logic taken);
        put(enc_b(8, rs2, rs1, f3));
        if (taken) begin
            put(enc_s(12'h3fc, 1, 0, 2));
        end else begin
            store_word(1, 100);
        end
    endtask

    task automatic build_program();
        logic [31:0] pc;
        n_rows = 0;
        n_exp = 0;
        n_loads = 0;
        st_addr = 32'h200;
        put(enc_i(100, 0, 0, 1, 7'h13));
        put(enc_i(-7, 0, 0, 2, 7'h13));
        put(enc_i(3, 0, 0, 4, 7'h13));
        // register forms, x1 = 100 and x2 = -7
        run_and_store(enc_r(0, 2, 1, 0, 3), 3, 93);
        run_and_store(enc_r(32, 2, 1, 0, 3), 3, 107);
        run_and_store(enc_r(0, 1, 2, 2, 3), 3, 1);
        run_and_store(enc_r(0, 1, 2, 3, 3), 3, 0);
        run_and_store(enc_r(0, 2, 1, 4, 3), 3, 32'd100 ^ 32'hfffffff9);
        run_and_store(enc_r(0, 2, 1, 6, 3), 3, 32'd100 | 32'hfffffff9);
        run_and_store(enc_r(0, 2, 1, 7, 3), 3, 32'd100 & 32'hfffffff9);
        run_and_store(enc_r(0, 4, 1, 1, 3), 3, 800);
        run_and_store(enc_r(0, 4, 2, 5, 3), 3, 32'hfffffff9 >> 3);
        run_and_store(enc_r(32, 4, 2, 5, 3), 3, 32'hffffffff);
        // immediate forms
        run_and_store(enc_i(-5, 2, 2, 3, 7'h13), 3, 1);
        run_and_store(enc_i(50, 1, 3, 3, 7'h13), 3, 0);
        run_and_store(enc_i(240, 1, 4, 3, 7'h13), 3, 32'd100 ^ 32'd240);
        run_and_store(enc_i(240, 1, 6, 3, 7'h13), 3, 32'd100 | 32'd240);
        run_and_store(enc_i(240, 1, 7, 3, 7'h13), 3, 32'd100 & 32'd240);
        run_and_store(enc_i(4, 1, 1, 3, 7'h13), 3, 1600);
        run_and_store(enc_i(28, 2, 5, 3, 7'h13), 3, 32'hf);
        run_and_store(enc_i(12'h401, 2, 5, 3, 7'h13), 3, 32'hfffffffc);
        run_and_store(enc_u(20'h12345, 5, 7'h37), 5, 32'h12345000);
        pc = n_rows * 4;
        run_and_store(enc_u(1, 5, 7'h17), 5, pc + 32'h1000);
        // x0 ignores writes
        run_and_store(enc_i(55, 0, 0, 0, 7'h13), 0, 0);
        // sub-word stores and loads
        put(enc_i(-91, 0, 0, 6, 7'h13));
        for (int k = 0; k < 4; k++) begin
            put_store(enc_s(32'h300 + k, 6, 0, 0), 32'h300, 32'hffffffa5 << (8 * k),
                      4'b0001 << k);
        end
        put(enc_u(8, 7, 7'h37));
        put(enc_i(1, 7, 0, 7, 7'h13));
        put_store(enc_s(32'h304, 7, 0, 1), 32'h304, 32'h8001, 4'b0011);
        put_store(enc_s(32'h306, 7, 0, 1), 32'h304, 32'h80010000, 4'b1100);
        load_and_store(enc_i(32'h301, 0, 0, 8, 7'h03), 8, 32'hffffffa5);
        load_and_store(enc_i(32'h302, 0, 4, 8, 7'h03), 8, 32'ha5);
        load_and_store(enc_i(32'h306, 0, 1, 8, 7'h03), 8, 32'hffff8001);
        load_and_store(enc_i(32'h304, 0, 5, 8, 7'h03), 8, 32'h8001);
        // branches, each taken then not taken
        branch_case(0, 1, 1, 1);
        branch_case(0, 1, 2, 0);
        branch_case(1, 1, 2, 1);
        branch_case(1, 1, 1, 0);
        branch_case(4, 2, 1, 1);
        branch_case(4, 1, 2, 0);
        branch_case(5, 1, 2, 1);
        branch_case(5, 2, 1, 0);
        branch_case(6, 1, 2, 1);
        branch_case(6, 2, 1, 0);
        branch_case(7, 2, 1, 1);
        branch_case(7, 1, 2, 0);
        // jumps
        pc = n_rows * 4;
        put(enc_j(8, 9));
        put(enc_s(12'h3fc, 1, 0, 2));
        store_word(9, pc + 4);
        pc = (n_rows + 1) * 4;
        put(enc_i(pc + 8, 0, 0, 10, 7'h13));
        put(enc_i(0, 10, 0, 11, 7'h67));
        put(enc_s(12'h3fc, 1, 0, 2));
        store_word(11, pc + 4);
        // ecall, then stores that must never run
        put(32'h00000073);
        put(enc_s(12'h3fc, 1, 0, 2));
        put(enc_s(12'h3f8, 2, 0, 2));
    endtask

    always #(PERIOD / 2) clk = ~clk;

    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(posedge clk) begin
        if (dmem_w_en) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem_mask[b]) begin
                    dmem[dmem_addr[9:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
                end
            end
        end
    end

    rv_core #(.RESET_PC(32'h0)) dut0 (
        .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_mask(dmem_mask),
        .dmem_w_en(dmem_w_en), .dmem_r_en(dmem_r_en), .dmem_rdata(dmem_rdata),
        .halted(halted)
    );

    core_checker #(.MAX_STORES(64)) checker0 (
        .clk(clk), .rst_n(rst_n), .dmem_w_en(dmem_w_en), .dmem_r_en(dmem_r_en),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_mask(dmem_mask),
        .halted(halted), .exp_addr(exp_addr), .exp_data(exp_data), .exp_mask(exp_mask),
        .n_exp(n_exp), .n_loads(n_loads), .error_count(error_count),
        .store_count(store_count), .load_count(load_count)
    );

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        seed = 84527;
        build_program();
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'h00000073;
            dmem[i] = $random(seed);
        end
        for (int i = 0; i < n_rows; i++) begin
            imem[i] = prog[i];
        end
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        wait (halted);
        repeat (4) @(negedge clk);
        if (store_count < n_exp) begin
            $display("%0d expected stores never happened", n_exp - store_count);
        end
        if (load_count < n_loads) begin
            $display("%0d expected loads never happened", n_loads - load_count);
        end
        $display("errors: %0d, stores seen: %0d of %0d, loads seen: %0d of %0d",
                 error_count, store_count, n_exp, load_count, n_loads);
        if (error_count == 0 && store_count == n_exp && load_count == n_loads) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(PERIOD / 2);
        #(4 * n_rows * PERIOD);
        $display("timeout: the core never halted");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
logic/rv_pkg.sv
logic/rv_ctrl.sv
logic/rv_decode.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_lsu.sv
logic/rv_fetch.sv
logic/rv_core.sv
bench/core_checker.sv
bench/tb_core.sv

//--- run.sh
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module tb_core -o tb_core

./obj_dir/tb_core > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0
